/* design/ifetch_ctrl.sv */
`timescale 1ns/10ps
`include "ifetch_macros.svh"

module ifetch_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  input  ifetch_pkg::pc_t        rst_vec,
  output logic                   req_valid,
  output ifetch_pkg::fetch_req_t req,
  input  logic                   req_ready,
  input  logic                   rsp_valid,
  output logic                   rsp_ready,
  input  logic                   flush_req,
  input  ifetch_pkg::flush_t     flush,
  input  logic                   halt_req,
  output logic                   halt_ack,
  input  ifetch_pkg::bjp_pred_t  pred,
  input  logic                   ir_accept,
  output logic                   ir_load,
  output logic                   ir_drop,
  output ifetch_pkg::pc_t        pc
);

  logic            req_hsk;
  logic            rsp_hsk;
  logic            reset_flag;
  logic            reset_req;
  logic            dly_flush;
  logic            out_flag;
  logic            req_pend;
  logic            flush_active;
  logic            bjp_req;
  logic            can_issue;
  logic            slot_free;
  logic            no_outs;
  ifetch_pkg::pc_t add_op1;
  ifetch_pkg::pc_t add_op2;
  ifetch_pkg::pc_t pc_sum;
  ifetch_pkg::pc_t pc_nxt;

  assign req_hsk = req_valid & req_ready;
  assign rsp_hsk = rsp_valid & rsp_ready;

  ////////////////////////////////////////////////////////////////////////
  // Reset and flush tracking
  ////////////////////////////////////////////////////////////////////////

  // High through reset, drops at the first edge out of it
  always_ff @(posedge clk) begin
    reset_flag <= rst;
  end

  // Fetch from the reset vector once, right after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      reset_req <= 1'b0;
    end else if (reset_flag & ~reset_req) begin
      reset_req <= 1'b1;
    end else if (req_hsk) begin
      reset_req <= 1'b0;
    end
  end

  // Flush is always taken, remember it if no request went out with it
  always_ff @(posedge clk) begin
    if (rst) begin
      dly_flush <= 1'b0;
    end else if (flush_req & ~req_hsk) begin
      dly_flush <= 1'b1;
    end else if (req_hsk) begin
      dly_flush <= 1'b0;
    end
  end

  assign flush_active = flush_req | dly_flush;

  ////////////////////////////////////////////////////////////////////////
  // Outstanding request and halt
  ////////////////////////////////////////////////////////////////////////

  // Set wins over clear when a response and a new request meet
  always_ff @(posedge clk) begin
    if (rst) begin
      out_flag <= 1'b0;
    end else if (req_hsk) begin
      out_flag <= 1'b1;
    end else if (rsp_hsk) begin
      out_flag <= 1'b0;
    end
  end

  // Request shown but not yet taken by the bus, keep it up
  always_ff @(posedge clk) begin
    if (rst) begin
      req_pend <= 1'b0;
    end else begin
      req_pend <= req_valid & ~req_ready;
    end
  end

  // Response on the bus counts as nothing in flight
  assign no_outs = ~out_flag | rsp_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      halt_ack <= 1'b0;
    end else if (halt_req & ~halt_ack & no_outs & ~req_valid) begin
      halt_ack <= 1'b1;
    end else if (halt_ack & ~halt_req) begin
      halt_ack <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Request and response handshakes
  ////////////////////////////////////////////////////////////////////////

  // Reason to fetch, blocked entirely while halted
  assign can_issue = ~halt_ack &
                     ((~halt_req & ~reset_flag) | reset_req | flush_active | req_pend);

  // Bus slot free, or the pending response can be retired now
  assign slot_free = ~out_flag | (rsp_valid & (flush_active | ir_accept));

  assign req_valid = can_issue & slot_free;

  // Response retires with the next request, or is discarded on flush
  assign rsp_ready = flush_active | (ir_accept & req_ready & can_issue);

  assign ir_load = rsp_hsk & ~flush_active;
  assign ir_drop = flush_req;

  ////////////////////////////////////////////////////////////////////////
  // Next PC
  ////////////////////////////////////////////////////////////////////////

  assign bjp_req = rsp_valid & pred.bjp & pred.taken;

  // One adder, operands picked by priority
  always_comb begin
    if (flush_req) begin
      add_op1 = flush.add_op1;
      add_op2 = flush.add_op2;
    end else if (dly_flush) begin
      // PC already holds the flush target
      add_op1 = pc;
      add_op2 = '0;
    end else if (bjp_req) begin
      add_op1 = pc;
      add_op2 = pred.offset;
    end else if (reset_req) begin
      add_op1 = rst_vec;
      add_op2 = '0;
    end else begin
      add_op1 = pc;
      add_op2 = ifetch_pkg::pc_t'(`IFETCH_PC_INCR);
    end
  end

  assign pc_sum = add_op1 + add_op2;
  assign pc_nxt = {pc_sum[`IFETCH_PC_SIZE-1:1], 1'b0};

  assign req.pc  = pc_nxt;
  assign req.seq = ~flush_active & ~bjp_req & ~reset_req;

  // Tracks the outstanding request address
  always_ff @(posedge clk) begin
    if (req_hsk | flush_req) begin
      pc <= pc_nxt;
    end
  end

endmodule

/* design/ifetch_ir.sv */
`timescale 1ns/10ps

module ifetch_ir (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   ir_load,
  input  logic                   ir_drop,
  input  ifetch_pkg::fetch_rsp_t rsp,
  input  ifetch_pkg::pc_t        pc,
  input  logic                   prdt_taken,
  output logic                   ir_valid,
  output ifetch_pkg::ir_t        ir,
  input  logic                   ir_ready,
  output logic                   ir_accept
);

  logic ir_hsk;

  assign ir_hsk = ir_valid & ir_ready;

  // Room for a new word when empty or draining this cycle
  assign ir_accept = ~ir_valid | ir_hsk;

  ////////////////////////////////////////////////////////////////////////
  // Valid flag
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      ir_valid <= 1'b0;
    end else if (ir_load) begin
      ir_valid <= 1'b1;
    end else if (ir_hsk | (ir_drop & ir_valid)) begin
      ir_valid <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Payload
  ////////////////////////////////////////////////////////////////////////

  // Held as is until the next load
  always_ff @(posedge clk) begin
    if (ir_load) begin
      ir.instr      <= rsp.instr;
      ir.pc         <= pc;
      ir.buserr     <= rsp.err;
      ir.prdt_taken <= prdt_taken;
    end
  end

endmodule

/* design/ifetch_macros.svh */
`ifndef IFETCH_MACROS_SVH
`define IFETCH_MACROS_SVH

////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////

// Program counter width
`define IFETCH_PC_SIZE 32

// Instruction word width, only full 32-bit encodings are fetched
`define IFETCH_INSTR_SIZE 32

////////////////////////////////////////////////////////////////////////
// Fetch constants
////////////////////////////////////////////////////////////////////////

// Sequential step between two aligned words
`define IFETCH_PC_INCR 4

`endif

/* design/ifetch_pkg.sv */
`include "ifetch_macros.svh"

package ifetch_pkg;

  ////////////////////////////////////////////////////////////////////////
  // Opcodes seen by the predecoder
  ////////////////////////////////////////////////////////////////////////

  // Major opcode field, bits [6:0] of the instruction
  // Anything not listed here is a plain non-control instruction
  typedef enum logic [6:0] {
    OP_BRANCH = 7'b110_0011,
    OP_JALR   = 7'b110_0111,
    OP_JAL    = 7'b110_1111
  } opcode_e;

  ////////////////////////////////////////////////////////////////////////
  // Basic words
  ////////////////////////////////////////////////////////////////////////

  typedef logic [`IFETCH_PC_SIZE-1:0]    pc_t;
  typedef logic [`IFETCH_INSTR_SIZE-1:0] instr_t;

  ////////////////////////////////////////////////////////////////////////
  // Channel payloads
  ////////////////////////////////////////////////////////////////////////

  // Fetch request, seq marks a plain pc+4 step
  typedef struct packed {
    pc_t  pc;
    logic seq;
  } fetch_req_t;

  // Fetch response with bus error flag
  typedef struct packed {
    instr_t instr;
    logic   err;
  } fetch_rsp_t;

  // Flush target is add_op1 + add_op2
  typedef struct packed {
    pc_t add_op1;
    pc_t add_op2;
  } flush_t;

  // Predecode result for the returned word
  typedef struct packed {
    logic bjp;
    logic taken;
    pc_t  offset;
  } bjp_pred_t;

  // Instruction register contents toward execute
  typedef struct packed {
    instr_t instr;
    pc_t    pc;
    logic   buserr;
    logic   prdt_taken;
  } ir_t;

endpackage

/* design/ifetch_predecode.sv */
`timescale 1ns/10ps

module ifetch_predecode (
  input  ifetch_pkg::instr_t    instr,
  output ifetch_pkg::bjp_pred_t pred
);

  ////////////////////////////////////////////////////////////////////////
  // Field extraction
  ////////////////////////////////////////////////////////////////////////

  ifetch_pkg::opcode_e opcode;
  ifetch_pkg::pc_t     imm_j;
  ifetch_pkg::pc_t     imm_b;
  ifetch_pkg::pc_t     imm_i;

  // Major opcode, low two bits are 2'b11 for every 32-bit encoding
  assign opcode = ifetch_pkg::opcode_e'(instr[6:0]);

  // J-type immediate
  // Bit 20 of the offset sits in instr[31], bit 0 is implied zero
  assign imm_j = {{12{instr[31]}},
                  instr[19:12],
                  instr[20],
                  instr[30:21],
                  1'b0};

  // B-type immediate
  // Scrambled the same way as stores, again with implied bit 0
  assign imm_b = {{20{instr[31]}},
                  instr[7],
                  instr[30:25],
                  instr[11:8],
                  1'b0};

  // I-type immediate, only meaningful for JALR here
  assign imm_i = {{20{instr[31]}}, instr[31:20]};

  ////////////////////////////////////////////////////////////////////////
  // Static prediction
  ////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Non-control by default
    pred.bjp    = 1'b0;
    pred.taken  = 1'b0;
    pred.offset = '0;

    case (opcode)
      ifetch_pkg::OP_JAL: begin
        // Unconditional jump, always redirect
        pred.bjp    = 1'b1;
        pred.taken  = 1'b1;
        pred.offset = imm_j;
      end
      ifetch_pkg::OP_BRANCH: begin
        // Backward branch taken, forward branch falls through
        pred.bjp    = 1'b1;
        pred.taken  = imm_b[31];
        pred.offset = imm_b;
      end
      ifetch_pkg::OP_JALR: begin
        // Register target unknown at fetch, so fall through
        pred.bjp    = 1'b1;
        pred.taken  = 1'b0;
        pred.offset = imm_i;
      end
      default: begin
        pred.bjp = 1'b0;
      end
    endcase
  end

endmodule

/* design/ifetch_top.sv */
`timescale 1ns/10ps

module ifetch_top (
  input  logic                   clk,
  input  logic                   rst,
  input  ifetch_pkg::pc_t        rst_vec,
  output logic                   req_valid,
  output ifetch_pkg::fetch_req_t req,
  input  logic                   req_ready,
  input  logic                   rsp_valid,
  input  ifetch_pkg::fetch_rsp_t rsp,
  output logic                   rsp_ready,
  output logic                   ir_valid,
  output ifetch_pkg::ir_t        ir,
  input  logic                   ir_ready,
  input  logic                   flush_req,
  input  ifetch_pkg::flush_t     flush,
  input  logic                   halt_req,
  output logic                   halt_ack
);

  ifetch_pkg::bjp_pred_t pred;
  ifetch_pkg::pc_t       pc;
  logic                  ir_accept;
  logic                  ir_load;
  logic                  ir_drop;

  // Predecode looks straight at the bus response
  ifetch_predecode ifetch_predecode_inst (
    .instr (rsp.instr),
    .pred  (pred)
  );

  ifetch_ctrl ifetch_ctrl_inst (
    .clk       (clk),
    .rst       (rst),
    .rst_vec   (rst_vec),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .flush_req (flush_req),
    .flush     (flush),
    .halt_req  (halt_req),
    .halt_ack  (halt_ack),
    .pred      (pred),
    .ir_accept (ir_accept),
    .ir_load   (ir_load),
    .ir_drop   (ir_drop),
    .pc        (pc)
  );

  ifetch_ir ifetch_ir_inst (
    .clk        (clk),
    .rst        (rst),
    .ir_load    (ir_load),
    .ir_drop    (ir_drop),
    .rsp        (rsp),
    .pc         (pc),
    .prdt_taken (pred.taken),
    .ir_valid   (ir_valid),
    .ir         (ir),
    .ir_ready   (ir_ready),
    .ir_accept  (ir_accept)
  );

endmodule

/* ifetch.f */
+incdir+design
design/ifetch_pkg.sv
design/ifetch_predecode.sv
design/ifetch_ctrl.sv
design/ifetch_ir.sv
design/ifetch_top.sv
verif/ifetch_chk.sv
verif/ifetch_tb.sv

/* run.sh */
#!/bin/bash
rm -f sim.log
verilator --binary --timing --assert --top-module ifetch_tb -f ifetch.f -o sim_ifetch \
  && ./obj_dir/sim_ifetch > sim.log 2>&1 \
  || echo "build or simulation exited with an error" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0

/* verif/ifetch_chk.sv */
`timescale 1ns/10ps

module ifetch_chk (
  input logic            clk,
  input logic            rst,
  input logic            req_valid,
  input logic            req_ready,
  input logic            rsp_valid,
  input logic            rsp_ready,
  input logic            ir_valid,
  input logic            ir_ready,
  input ifetch_pkg::ir_t ir,
  input logic            flush_req,
  input logic            halt_ack
);

  // Own copy of the in-flight state, one request at most
  logic outs;

  always_ff @(posedge clk) begin
    if (rst) begin
      outs <= 1'b0;
    end else if (req_valid & req_ready) begin
      outs <= 1'b1;
    end else if (rsp_valid & rsp_ready) begin
      outs <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Request channel
  //////////////////////////////////////////////////////////////////////

  // A shown request stays up until taken
  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    req_valid && !req_ready |=> req_valid)
    else $error("req_valid dropped before transfer");

  // Second request only together with the response of the first
  a_one_outs: assert property (@(posedge clk) disable iff (rst)
    req_valid && req_ready && outs |-> rsp_valid && rsp_ready)
    else $error("second request while one is outstanding");

  //////////////////////////////////////////////////////////////////////
  // Execute channel and halt
  //////////////////////////////////////////////////////////////////////

  a_ir_stable: assert property (@(posedge clk) disable iff (rst)
    ir_valid && !ir_ready && !flush_req |=> ir_valid && $stable(ir))
    else $error("IR changed while stalled");

  a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
    halt_ack |-> !(req_valid && req_ready))
    else $error("request transferred while halted");

endmodule

bind ifetch_top ifetch_chk ifetch_chk_inst (
  .clk       (clk),
  .rst       (rst),
  .req_valid (req_valid),
  .req_ready (req_ready),
  .rsp_valid (rsp_valid),
  .rsp_ready (rsp_ready),
  .ir_valid  (ir_valid),
  .ir_ready  (ir_ready),
  .ir        (ir),
  .flush_req (flush_req),
  .halt_ack  (halt_ack)
);

/* verif/ifetch_tb.sv */
`timescale 1ns/10ps
`include "ifetch_macros.svh"

module ifetch_tb;

  localparam logic [31:0] BASE = 32'h0000_1000;
  localparam logic [31:0] SEED = 32'hc9d8_da08;

  logic clk = 1'b0;
  logic rst;
  ifetch_pkg::pc_t        rst_vec;
  logic                   req_valid;
  ifetch_pkg::fetch_req_t req;
  logic                   req_ready;
  logic                   rsp_valid;
  ifetch_pkg::fetch_rsp_t rsp;
  logic                   rsp_ready;
  logic                   ir_valid;
  ifetch_pkg::ir_t        ir;
  logic                   ir_ready;
  logic                   flush_req;
  ifetch_pkg::flush_t     flush;
  logic                   halt_req;
  logic                   halt_ack;

  ifetch_pkg::instr_t mem [0:63];
  ifetch_pkg::pc_t    pend_q[$];
  ifetch_pkg::pc_t    exp_pc;
  ifetch_pkg::pc_t    last_req_pc;
  logic               first_req_seen;
  logic               first_checked;
  logic               flush_seen;
  int                 cyc;
  int                 xfer_cnt;
  int                 jal_cnt;
  int                 back_cnt;
  int                 fwd_cnt;
  int                 err_cnt;
  int                 seq_cnt;

  always #4 clk = ~clk;

  ifetch_top ifetch_top_inst (.*);

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Words in this window answer with a bus error
  function automatic logic in_err_window(input ifetch_pkg::pc_t pc);
    return (pc >= BASE + 32'h70) && (pc <= BASE + 32'h7c);
  endfunction

  function automatic ifetch_pkg::instr_t enc_jal(input logic [31:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'h6f};
  endfunction

  function automatic ifetch_pkg::instr_t enc_branch(input logic [31:0] off);
    return {off[12], off[10:5], 5'd2, 5'd1, 3'b001, off[4:1], off[11], 7'h63};
  endfunction

  // Static rule: JAL taken, branch taken only when backward
  function automatic ifetch_pkg::pc_t ref_next_pc(input ifetch_pkg::pc_t pc,
                                                  input ifetch_pkg::instr_t ins,
                                                  output logic taken);
    ifetch_pkg::pc_t imm;
    ifetch_pkg::pc_t nxt;
    taken = 1'b0;
    imm   = 32'(`IFETCH_PC_INCR);
    if (ins[6:0] == 7'h6f) begin
      imm   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      taken = 1'b1;
    end else if (ins[6:0] == 7'h63 && ins[31]) begin
      imm   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      taken = 1'b1;
    end
    nxt = pc + imm;
    return {nxt[31:1], 1'b0};
  endfunction

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "testbench stopped on error");
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    abort_run();
  endtask

  task automatic check_pc(input string name, input ifetch_pkg::pc_t e,
                          input ifetch_pkg::pc_t a);
    if (e !== a) begin
      $display("CHECK FAILED %s expected %h actual %h", name, e, a);
      abort_run();
    end
  endtask

  task automatic check_instr(input string name, input ifetch_pkg::instr_t e,
                             input ifetch_pkg::instr_t a);
    if (e !== a) begin
      $display("CHECK FAILED %s expected %h actual %h", name, e, a);
      abort_run();
    end
  endtask

  task automatic check_ir(input string name, input ifetch_pkg::ir_t e,
                          input ifetch_pkg::ir_t a);
    if (e !== a) begin
      $display("CHECK FAILED %s expected %h actual %h", name, e, a);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic e, input logic a);
    if (e !== a) begin
      $display("CHECK FAILED %s expected %b actual %b", name, e, a);
      abort_run();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_xfers(input int n);
    int t;
    t = 0;
    while (xfer_cnt < n) begin
      next_cycle();
      t++;
      if (t > 3000) report_failure("timeout waiting for IR transfers");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Memory model, one response per request after 0 to 3 cycles
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]     rng;
    int              dly;
    logic            rsp_done;
    ifetch_pkg::pc_t addr;
    rng       = SEED;
    dly       = 0;
    req_ready = 1'b0;
    rsp_valid = 1'b0;
    rsp       = '0;
    ir_ready  = 1'b0;
    for (int i = 0; i < 64; i++) begin
      // Plain ADDI words, upper bits fold the whole word address
      addr   = BASE + 32'(i * 4);
      mem[i] = {addr[31:7] ^ addr[24:0], 7'h13};
    end
    mem[4]  = enc_jal(32'd24);
    mem[12] = enc_branch(32'd16);
    mem[18] = enc_branch(-32'sd16);
    forever begin
      @(posedge clk);
      rsp_done = rsp_valid && rsp_ready && !rst;
      if (rsp_done) void'(pend_q.pop_front());
      if (!rst && req_valid && req_ready) begin
        if (pend_q.size() == 0) dly = int'(rng[1:0]);
        pend_q.push_back(req.pc);
      end
      #1;
      rng       = xorshift(rng);
      req_ready = (rng[3:2] != 2'b00);
      ir_ready  = (rng[5:4] != 2'b00);
      if (rsp_done) begin
        rsp_valid = 1'b0;
        dly       = int'(rng[7:6]);
      end
      if (!rsp_valid && pend_q.size() != 0) begin
        if (dly == 0) begin
          rsp_valid = 1'b1;
          rsp.instr = mem[pend_q[0][7:2]];
          rsp.err   = in_err_window(pend_q[0]);
        end else begin
          dly--;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Comparing process
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    ifetch_pkg::ir_t    exp_ir;
    ifetch_pkg::instr_t ins;
    ifetch_pkg::pc_t    nxt;
    logic               tk;
    if (rst) begin
      exp_pc         = rst_vec;
      first_req_seen = 1'b0;
      first_checked  = 1'b0;
      flush_seen     = 1'b0;
      cyc            = 0;
    end else begin
      cyc++;
      if (req_valid && !first_checked) begin
        check_flag("first_req_cycle", 1'b1, cyc == 2);
        check_pc("first_req_pc", rst_vec, req.pc);
        check_flag("first_req_seq", 1'b0, req.seq);
        first_checked = 1'b1;
      end
      // A flush restarts the request chain from its target
      if (flush_req) flush_seen = 1'b1;
      if (req_valid && req_ready) begin
        if (halt_req && halt_ack) report_failure("request transferred while halted");
        // Next request leaves with the response of the previous one
        if (first_req_seen && !flush_seen) begin
          nxt = ref_next_pc(last_req_pc, mem[last_req_pc[7:2]], tk);
          check_pc("req_pc", nxt, req.pc);
          check_flag("req_seq", !tk, req.seq);
          if (req.seq) seq_cnt++;
        end
        first_req_seen = 1'b1;
        flush_seen     = 1'b0;
        last_req_pc    = req.pc;
      end
      // Transfer in the flush cycle still belongs to the old path
      if (ir_valid && ir_ready) begin
        ins = mem[exp_pc[7:2]];
        nxt = ref_next_pc(exp_pc, ins, tk);
        exp_ir.instr      = ins;
        exp_ir.pc         = exp_pc;
        exp_ir.buserr     = in_err_window(exp_pc);
        exp_ir.prdt_taken = tk;
        check_pc("ir_pc", exp_ir.pc, ir.pc);
        check_instr("ir_instr", exp_ir.instr, ir.instr);
        check_ir("ir_word", exp_ir, ir);
        if (ins[6:0] == 7'h6f) jal_cnt++;
        if (ins[6:0] == 7'h63 && tk) back_cnt++;
        if (ins[6:0] == 7'h63 && !tk) fwd_cnt++;
        if (exp_ir.buserr) err_cnt++;
        exp_pc = nxt;
        xfer_cnt++;
      end
      if (flush_req) begin
        nxt    = flush.add_op1 + flush.add_op2;
        exp_pc = {nxt[31:1], 1'b0};
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] srng;
    logic [5:0]  idx;
    int          t;
    srng      = xorshift(SEED);
    rst       = 1'b1;
    rst_vec   = BASE;
    flush_req = 1'b0;
    flush     = '0;
    halt_req  = 1'b0;
    xfer_cnt  = 0;
    {jal_cnt, back_cnt, fwd_cnt, err_cnt, seq_cnt} = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    wait_xfers(20);

    // Flushes at random points, first one lands in the error window
    for (int n = 0; n < 12; n++) begin
      srng = xorshift(srng);
      repeat (int'(srng[4:0])) next_cycle();
      idx           = (n == 0) ? 6'd28 : srng[13:8];
      flush.add_op1 = BASE + {24'h0, idx, 2'b00} - 32'd4;
      flush.add_op2 = 32'd5;
      flush_req     = 1'b1;
      next_cycle();
      flush_req = 1'b0;
      wait_xfers(xfer_cnt + 6);
    end

    // Halt with fetching live, then resume
    halt_req = 1'b1;
    t = 0;
    while (!halt_ack) begin
      next_cycle();
      t++;
      if (t > 100) report_failure("timeout waiting for halt_ack to rise");
    end
    repeat (20) next_cycle();
    halt_req = 1'b0;
    t = 0;
    while (halt_ack) begin
      next_cycle();
      t++;
      if (t > 4) report_failure("timeout waiting for halt_ack to fall");
    end
    wait_xfers(xfer_cnt + 40);

    check_flag("cover_jal", 1'b1, jal_cnt > 0);
    check_flag("cover_back_branch", 1'b1, back_cnt > 0);
    check_flag("cover_fwd_branch", 1'b1, fwd_cnt > 0);
    check_flag("cover_buserr", 1'b1, err_cnt > 0);
    check_flag("cover_seq_req", 1'b1, seq_cnt > 0);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
